/* Makefile */
TOP = tb_sign_decision

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir

/* bench/sign_decision_asserts.sv */
/*
  Handshake assertions for the sign decision top
*/

`timescale 1ns/10ps

module sign_decision_asserts (
  input logic              clk,
  input logic              resetn,
  input logic              i_score_req,
  input logic              o_score_ack,
  input logic              i_rpt_ack,
  input logic              o_rpt_req,
  input sign_pkg::report_t o_rpt
);

  int n_fail = 0;

  // Score sender holds req until ack is up
  a_score_req: assert property (@(posedge clk) disable iff (!resetn)
    $fell(i_score_req) |-> o_score_ack)
    else
    begin
      n_fail++;
      $error("i_score_req fell before o_score_ack was high");
    end

  a_rpt_req: assert property (@(posedge clk) disable iff (!resetn)
    $fell(o_rpt_req) |-> $past(i_rpt_ack))
    else
    begin
      n_fail++;
      $error("o_rpt_req fell before i_rpt_ack was high");
    end

  // Report payload frozen for the whole request
  a_rpt_stable: assert property (@(posedge clk) disable iff (!resetn)
    (o_rpt_req && $past(o_rpt_req)) |-> $stable(o_rpt))
    else
    begin
      n_fail++;
      $error("o_rpt changed while o_rpt_req was high");
    end

  a_ack_rise: assert property (@(posedge clk) disable iff (!resetn)
    $rose(o_score_ack) |-> $past(i_score_req))
    else
    begin
      n_fail++;
      $error("o_score_ack rose without i_score_req");
    end

endmodule

bind sign_decision_top sign_decision_asserts u_asserts (
  .clk         (clk),
  .resetn      (resetn),
  .i_score_req (i_score_req),
  .o_score_ack (o_score_ack),
  .i_rpt_ack   (i_rpt_ack),
  .o_rpt_req   (o_rpt_req),
  .o_rpt       (o_rpt)
);

/* bench/tb_clock_gen.sv */
/*
  Testbench clock and reset, 20 ns period with reset held for 16 cycles
*/

`timescale 1ns/10ps

module tb_clock_gen (
  output logic o_clk,
  output logic o_resetn
);

  initial
  begin
    o_clk = 1'b0;
    forever #10 o_clk = ~o_clk;  // 20 ns period
  end

  initial
  begin
    o_resetn = 1'b0;
    repeat (16) @(posedge o_clk);
    @(negedge o_clk);
    o_resetn = 1'b1;  // Released away from the sampling edge
  end

endmodule

/* bench/tb_sign_decision.sv */
/*
  Sign decision testbench
  Sends score frames, answers reports after random delays, checks every report
*/

`timescale 1ns/10ps

module tb_sign_decision;

  localparam int WAIT_MAX = 2000;  // Cycles allowed per wait

  typedef struct packed {
    logic [sign_pkg::IDX_W-1:0] last_idx;
    logic [sign_pkg::IDX_W-1:0] filt_idx;
    logic [sign_pkg::CNT_W-1:0] cnt;
  } filt_state_t;

  logic                          clk;
  logic                          resetn;
  logic                          score_req;
  logic [sign_pkg::SCORE_W-1:0]  score;
  logic                          score_ack;
  logic                          rpt_req;
  logic                          rpt_ack;
  sign_pkg::report_t             rpt;

  sign_pkg::report_t exp_q[$];    // Expected reports, oldest first
  filt_state_t       model_st;
  logic [31:0]       rng_frame;
  logic [31:0]       rng_delay;
  logic [5:0]        delay_mask;  // Range of the report ack delay
  int                n_sent;
  int                n_rcvd;

  tb_clock_gen u_clock_gen (.o_clk(clk), .o_resetn(resetn));

  sign_decision_top dut (
    .clk         (clk),
    .resetn      (resetn),
    .i_score_req (score_req),
    .i_score     (score),
    .i_rpt_ack   (rpt_ack),
    .o_score_ack (score_ack),
    .o_rpt_req   (rpt_req),
    .o_rpt       (rpt)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "Run stopped");
  endtask

  // One cycle of a bounded wait
  task automatic tick(inout int n, input string what);
    @(negedge clk);
    n++;
    if (n > WAIT_MAX)
      fail_run({"Timeout waiting for ", what});
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("** Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      fail_run("Signal level does not match");
    end
  endtask

  task automatic check_report(input string name, input sign_pkg::report_t got,
                              input sign_pkg::report_t exp);
    if (got !== exp)
    begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      fail_run("Report does not match the reference");
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Expected report of one frame and the next model filter state
  function automatic sign_pkg::report_t ref_report(input sign_pkg::score_vec_t s,
                                                   inout filt_state_t st);
    sign_pkg::report_t            r;
    logic [sign_pkg::SCORE_W-1:0] best;
    logic [sign_pkg::SCORE_W-1:0] second;
    int                           bi;
    best   = s[0];
    bi     = 0;
    second = '0;
    for (int k = 1; k < sign_pkg::NUM_CLASSES; k++)
    begin
      if (s[k] > best)  // First of equal maxima stays
      begin
        best = s[k];
        bi   = k;
      end
    end
    for (int k = 0; k < sign_pkg::NUM_CLASSES; k++)
    begin
      if (k != bi && s[k] > second)
        second = s[k];
    end
    r.raw_idx = (sign_pkg::IDX_W)'(bi);
    r.margin  = best - second;
    if (r.margin < sign_pkg::CONF_TH)
      st.cnt = '0;
    else if (r.raw_idx != st.last_idx)
    begin
      st.cnt      = '0;
      st.last_idx = r.raw_idx;
    end
    else if (st.cnt < sign_pkg::STABLE_MAX)
      st.cnt = st.cnt + (sign_pkg::CNT_W)'(1);
    if (st.cnt >= sign_pkg::STABLE_MIN)
      st.filt_idx = st.last_idx;
    r.filt_idx = st.filt_idx;
    r.cnt      = st.cnt;
    return r;
  endfunction

  // Small distinct scores with the class number in the low nibble
  function automatic sign_pkg::score_vec_t random_frame();
    sign_pkg::score_vec_t s;
    for (int k = 0; k < sign_pkg::NUM_CLASSES; k++)
    begin
      rng_frame = xorshift(rng_frame);
      s[k] = {4'h0, rng_frame[7:0], (sign_pkg::IDX_W)'(k)};
    end
    return s;
  endfunction

  task automatic send_word(input logic [sign_pkg::SCORE_W-1:0] w);
    int n;
    @(negedge clk);
    score     = w;
    score_req = 1'b1;
    n = 0;
    while (score_ack !== 1'b1)
      tick(n, "o_score_ack to rise");
    score_req = 1'b0;
    n = 0;
    while (score_ack !== 1'b0)
      tick(n, "o_score_ack to fall");
  endtask

  task automatic send_frame(input sign_pkg::score_vec_t s);
    exp_q.push_back(ref_report(s, model_st));
    for (int k = 0; k < sign_pkg::NUM_CLASSES; k++)
      send_word(s[k]);
    n_sent++;
  endtask

  task automatic send_winner(input int w, input logic [3:0] top);
    sign_pkg::score_vec_t s;
    s = random_frame();
    s[w][15:12] = top;  // Lifts class w above the rest
    send_frame(s);
  endtask

  task automatic send_tie(input int a, input int b);
    sign_pkg::score_vec_t s;
    s = random_frame();
    s[a] = 16'h8000;
    s[b] = 16'h8000;
    send_frame(s);
  endtask

  // ==========================================================================
  // Report side answers each request and compares it
  // ==========================================================================

  initial
  begin : report_receiver
    sign_pkg::report_t got;
    int                n_delay;
    int                n;
    rpt_ack   = 1'b0;
    rng_delay = xorshift(32'h3eb6);
    n_rcvd    = 0;
    forever
    begin
      @(negedge clk);
      if (rpt_req === 1'b1)
      begin
        got = rpt;
        if (exp_q.size() == 0)
          fail_run("Report arrived with no frame outstanding");
        check_report("o_rpt", got, exp_q.pop_front());
        rng_delay = xorshift(rng_delay);
        n_delay   = int'(rng_delay[5:0] & delay_mask);
        repeat (n_delay) @(negedge clk);
        rpt_ack = 1'b1;
        n = 0;
        while (rpt_req !== 1'b0)
          tick(n, "o_rpt_req to fall");
        rpt_ack = 1'b0;
        n_rcvd++;
      end
    end
  end

  // ==========================================================================
  // Stimulus
  // ==========================================================================

  initial
  begin : stimulus
    int n;
    score_req  = 1'b0;
    score      = '0;
    model_st   = '0;
    rng_frame  = 32'h3eb6;
    delay_mask = 6'h03;
    n_sent     = 0;
    n = 0;
    while (resetn !== 1'b1)
      tick(n, "reset release");

    repeat (10)  // Quiet until the first word
    begin
      @(negedge clk);
      check_bit("o_score_ack", score_ack, 1'b0);
      check_bit("o_rpt_req", rpt_req, 1'b0);
    end

    send_winner(0, 4'h1);
    send_winner(sign_pkg::NUM_CLASSES - 1, 4'h1);
    for (int i = 0; i < 12; i++)
    begin
      rng_frame = xorshift(rng_frame);
      send_winner(int'(rng_frame[7:0]) % sign_pkg::NUM_CLASSES, 4'h1);
    end
    send_tie(0, 1);
    send_tie(2, 7);
    send_tie(4, 8);

    for (int i = 0; i < 3; i++)
      send_winner(3, 4'h2);  // Filtered index settles on another class first
    for (int i = 0; i < 18; i++)
      send_winner(5, 4'h4);  // Long enough to saturate the count
    send_tie(2, 3);          // Weak frame with a different winner breaks the run
    for (int i = 0; i < 4; i++)
      send_winner(5, 4'h4);

    delay_mask = 6'h3f;      // Slow receiver lets the chain back up
    for (int i = 0; i < 20; i++)
    begin
      rng_frame = xorshift(rng_frame);
      send_winner(int'(rng_frame[7:0]) % sign_pkg::NUM_CLASSES, 4'h1);
    end

    n = 0;
    while (n_rcvd != n_sent)
      tick(n, "outstanding reports");
    if (dut.u_asserts.n_fail == 0)
    begin
      $display("Everything OK");
      $finish;
    end
    else
      fail_run("A handshake assertion failed");
  end

endmodule

/* hdl/argmax_stage.sv */
/*
  Argmax stage
  Folds one class score into the running best and second-best
*/

`timescale 1ns/10ps

module argmax_stage (
  input  logic                        clk,
  input  logic                        resetn,
  input  sign_pkg::chain_item_t       i_item,
  input  logic [sign_pkg::IDX_W-1:0]  i_class,
  input  logic                        i_advance,
  output sign_pkg::chain_item_t       o_item
);

  logic                         r_valid;
  sign_pkg::score_vec_t         r_scores;
  sign_pkg::argmax_t            r_am;
  logic [sign_pkg::SCORE_W-1:0] w_score;
  sign_pkg::argmax_t            w_am;

  assign w_score = i_item.scores[i_class];

  // Strict compare, so a tie keeps the earlier (lower) index
  always_comb
  begin
    w_am = i_item.am;
    if (w_score > i_item.am.best)
    begin
      w_am.best   = w_score;
      w_am.second = i_item.am.best;  // Old best drops to second
      w_am.idx    = i_class;
    end
    else if (w_score > i_item.am.second)
    begin
      w_am.second = w_score;
    end
  end

  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
      r_valid <= 1'b0;
    else if (i_advance)
      r_valid <= i_item.valid;
  end

  always_ff @(posedge clk)
  begin
    if (i_advance)
    begin
      r_scores <= i_item.scores;
      r_am     <= w_am;
    end
  end

  assign o_item = {r_valid, r_scores, r_am};

endmodule

/* hdl/decision_filter.sv */
/*
  Decision filter
  Applies the confidence threshold and stability count to each frame result
  and sends one report per frame over a four-phase req/ack handshake
*/

`timescale 1ns/10ps

module decision_filter (
  input  logic                   clk,
  input  logic                   resetn,
  input  sign_pkg::chain_item_t  i_item,
  input  logic                   i_rpt_ack,
  output logic                   o_advance,
  output logic                   o_rpt_req,
  output sign_pkg::report_t      o_rpt
);

  // Filter state
  logic [sign_pkg::IDX_W-1:0]   r_last_idx;
  logic [sign_pkg::IDX_W-1:0]   r_filt_idx;
  logic [sign_pkg::CNT_W-1:0]   r_cnt;

  // Report handshake
  logic                         r_req;
  logic                         r_pend;   // From accept until ack seen low
  sign_pkg::report_t            r_rpt;

  logic                         w_accept;
  logic [sign_pkg::SCORE_W-1:0] w_margin;
  logic                         w_confident;
  logic [sign_pkg::IDX_W-1:0]   w_last_nxt;
  logic [sign_pkg::IDX_W-1:0]   w_filt_nxt;
  logic [sign_pkg::CNT_W-1:0]   w_cnt_nxt;

  // ==========================================================================
  // Chain flow
  // ==========================================================================

  // Freeze the chain only when a frame waits behind a pending report
  assign o_advance = !(r_pend && i_item.valid);
  assign w_accept  = i_item.valid && !r_pend;

  // ==========================================================================
  // Stability filter
  // ==========================================================================

  assign w_margin    = i_item.am.best - i_item.am.second;  // Never negative
  assign w_confident = (w_margin >= sign_pkg::CONF_TH);

  always_comb
  begin
    w_last_nxt = r_last_idx;
    w_cnt_nxt  = r_cnt;
    w_filt_nxt = r_filt_idx;

    if (!w_confident)
    begin
      w_cnt_nxt = '0;                 // Weak frame breaks the run
    end
    else if (i_item.am.idx != r_last_idx)
    begin
      w_cnt_nxt  = '0;
      w_last_nxt = i_item.am.idx;     // New candidate
    end
    else if (r_cnt != sign_pkg::STABLE_MAX)
    begin
      w_cnt_nxt = r_cnt + (sign_pkg::CNT_W)'(1);
    end

    // Decision moves only once the run is long enough
    if (w_cnt_nxt >= sign_pkg::STABLE_MIN)
      w_filt_nxt = w_last_nxt;
  end

  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
    begin
      r_last_idx <= '0;
      r_filt_idx <= '0;
      r_cnt      <= '0;
    end
    else if (w_accept)
    begin
      r_last_idx <= w_last_nxt;
      r_filt_idx <= w_filt_nxt;
      r_cnt      <= w_cnt_nxt;
    end
  end

  // ==========================================================================
  // Report handshake
  // ==========================================================================

  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
    begin
      r_req  <= 1'b0;
      r_pend <= 1'b0;
    end
    else if (w_accept)
    begin
      r_req  <= 1'b1;
      r_pend <= 1'b1;
    end
    else
    begin
      if (r_req && i_rpt_ack)
        r_req <= 1'b0;                // Receiver took it
      if (r_pend && !r_req && !i_rpt_ack)
        r_pend <= 1'b0;               // Ack back low, ready for next
    end
  end

  // Held steady for the whole handshake
  always_ff @(posedge clk)
  begin
    if (w_accept)
    begin
      r_rpt.raw_idx  <= i_item.am.idx;
      r_rpt.margin   <= w_margin;
      r_rpt.filt_idx <= w_filt_nxt;
      r_rpt.cnt      <= w_cnt_nxt;
    end
  end

  assign o_rpt_req = r_req;
  assign o_rpt     = r_rpt;

endmodule

/* hdl/score_collector.sv */
/*
  Score collector
  Receives class scores over a four-phase req/ack handshake and
  hands a complete frame to the first argmax stage
*/

`timescale 1ns/10ps

module score_collector (
  input  logic                          clk,
  input  logic                          resetn,
  input  logic                          i_score_req,
  input  logic [sign_pkg::SCORE_W-1:0]  i_score,
  input  logic                          i_advance,
  output logic                          o_score_ack,
  output sign_pkg::chain_item_t         o_item
);

  logic                                             r_ack;
  logic [sign_pkg::IDX_W-1:0]                       r_cnt;    // Next class expected
  logic [sign_pkg::NUM_CLASSES-2:0][sign_pkg::SCORE_W-1:0] r_words;  // Classes 0 to N-2
  logic                                             w_last;
  logic                                             w_take;

  // ==========================================================================
  // Handshake control
  // ==========================================================================

  assign w_last = (r_cnt == (sign_pkg::IDX_W)'(sign_pkg::NUM_CLASSES - 1));

  // Last word only goes through when the chain moves
  assign w_take = i_score_req && !r_ack && (!w_last || i_advance);

  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
    begin
      r_ack <= 1'b0;
      r_cnt <= '0;
    end
    else if (w_take)
    begin
      r_ack <= 1'b1;
      r_cnt <= w_last ? '0 : r_cnt + (sign_pkg::IDX_W)'(1);
    end
    else if (!i_score_req && r_ack)
    begin
      r_ack <= 1'b0;  // Sender released req
    end
  end

  assign o_score_ack = r_ack;

  // ==========================================================================
  // Word storage
  // ==========================================================================

  // Shift in from the top, so class 0 ends up in the lowest slot
  always_ff @(posedge clk)
  begin
    if (w_take && !w_last)
    begin
      r_words <= {i_score, r_words[sign_pkg::NUM_CLASSES-2:1]};
    end
  end

  // Frame is complete while the last word is on the bus
  always_comb
  begin
    o_item.valid  = i_score_req && !r_ack && w_last;
    o_item.scores = {i_score, r_words};
    o_item.am     = '0;  // Best, second and index start at zero
  end

endmodule

/* hdl/sign_decision_top.sv */
/*
  Sign decision top
  Score collector, argmax stage chain and decision filter
*/

`timescale 1ns/10ps

module sign_decision_top (
  input  logic                          clk,
  input  logic                          resetn,
  input  logic                          i_score_req,
  input  logic [sign_pkg::SCORE_W-1:0]  i_score,
  input  logic                          i_rpt_ack,
  output logic                          o_score_ack,
  output logic                          o_rpt_req,
  output sign_pkg::report_t             o_rpt
);

  // Entry k feeds stage k, the last entry feeds the filter
  sign_pkg::chain_item_t  w_chain [sign_pkg::NUM_CLASSES+1];
  logic                   w_advance;

  // ==========================================================================
  // Input side
  // ==========================================================================

  score_collector u_score_collector (
    .clk          (clk),
    .resetn       (resetn),
    .i_score_req  (i_score_req),
    .i_score      (i_score),
    .i_advance    (w_advance),
    .o_score_ack  (o_score_ack),
    .o_item       (w_chain[0])
  );

  // ==========================================================================
  // Argmax chain, one stage per class
  // ==========================================================================

  for (genvar k = 0; k < sign_pkg::NUM_CLASSES; k++)
  begin : g_stage
    argmax_stage u_argmax_stage (
      .clk        (clk),
      .resetn     (resetn),
      .i_item     (w_chain[k]),
      .i_class    ((sign_pkg::IDX_W)'(k)),  // Class folded in here
      .i_advance  (w_advance),
      .o_item     (w_chain[k+1])
    );
  end

  // ==========================================================================
  // Output side
  // ==========================================================================

  decision_filter u_decision_filter (
    .clk        (clk),
    .resetn     (resetn),
    .i_item     (w_chain[sign_pkg::NUM_CLASSES]),
    .i_rpt_ack  (i_rpt_ack),
    .o_advance  (w_advance),
    .o_rpt_req  (o_rpt_req),
    .o_rpt      (o_rpt)
  );

endmodule

/* hdl/sign_pkg.sv */
/*
  Sign decision shared definitions
  Sizes, decision thresholds and the types carried along the argmax chain
*/

package sign_pkg;

  // ==========================================================================
  // Sizes
  // ==========================================================================

  localparam int NUM_CLASSES = 9;   // Sign classes per frame
  localparam int SCORE_W     = 16;  // Classifier score width
  localparam int IDX_W       = 4;   // Class index width
  localparam int CNT_W       = 4;   // Stability counter width

  // ==========================================================================
  // Decision thresholds
  // ==========================================================================

  // Minimum best-to-second margin for a confident frame
  localparam logic [SCORE_W-1:0] CONF_TH    = 16'd10;
  localparam logic [CNT_W-1:0]   STABLE_MIN = 4'd2;   // Filtered index follows from here
  localparam logic [CNT_W-1:0]   STABLE_MAX = 4'd15;  // Count saturates here

  // ==========================================================================
  // Types
  // ==========================================================================

  // One score per class, class 0 in the lowest slot
  typedef logic [NUM_CLASSES-1:0][SCORE_W-1:0] score_vec_t;

  // Running result of the argmax fold
  typedef struct packed {
    logic [SCORE_W-1:0] best;
    logic [SCORE_W-1:0] second;
    logic [IDX_W-1:0]   idx;   // Class of best
  } argmax_t;

  // Item passed from stage to stage
  typedef struct packed {
    logic       valid;
    score_vec_t scores;
    argmax_t    am;
  } chain_item_t;

  // One report per frame
  typedef struct packed {
    logic [IDX_W-1:0]   raw_idx;   // Unfiltered winner
    logic [SCORE_W-1:0] margin;    // Best minus second
    logic [IDX_W-1:0]   filt_idx;  // Filtered decision
    logic [CNT_W-1:0]   cnt;       // Stability count
  } report_t;

endpackage

/* src.f */
hdl/sign_pkg.sv
hdl/score_collector.sv
hdl/argmax_stage.sv
hdl/decision_filter.sv
hdl/sign_decision_top.sv
bench/sign_decision_asserts.sv
bench/tb_clock_gen.sv
bench/tb_sign_decision.sv
